// File: filelist.f
+incdir+sim
hw/dsp_cfg_pkg.sv
hw/dsp_ctrl_pkg.sv
hw/alu_segment.sv
hw/simd_alu.sv
hw/operand_stage.sv
hw/dsp_slice.sv
sim/tb_dsp_slice.sv

// File: hw/alu_segment.sv
// SIMD ALU segment
`timescale 1ns/1ps

module alu_segment #(
	parameter int WIDTH = 12
) (
	input  logic [WIDTH-1:0]      w,
	input  logic [WIDTH-1:0]      x,
	input  logic [WIDTH-1:0]      y,
	input  logic [WIDTH-1:0]      z,
	input  dsp_ctrl_pkg::alu_op_e alu_op,
	input  logic [1:0]            sum_cin, // Three-operand chain carry, 0..3
	input  logic [1:0]            tot_cin,
	output logic [WIDTH-1:0]      s,
	output logic [1:0]            sum_cout,
	output logic [1:0]            tot_cout
);

	import dsp_ctrl_pkg::*;

	logic [WIDTH+1:0] sum_full;
	logic [WIDTH-1:0] v;
	logic [WIDTH-1:0] v_op;
	logic [WIDTH+1:0] tot_full;

	// First chain, w + x + y with a two-bit carry
	// Three full-width terms need two carry bits
	assign sum_full = {2'b00, w} + {2'b00, x} + {2'b00, y} + {{WIDTH{1'b0}}, sum_cin};
	assign v = sum_full[WIDTH-1:0];
	assign sum_cout = sum_full[WIDTH+1:WIDTH];

	// Ones complement of the adder term for z - v, the +1 arrives at the lane start
	assign v_op = (alu_op == OP_SUB) ? ~v : v;

	// Second chain adds z
	assign tot_full = {2'b00, z} + {2'b00, v_op} + {{WIDTH{1'b0}}, tot_cin};
	assign tot_cout = tot_full[WIDTH+1:WIDTH];

	// Logic ops combine z with the adder term
	always_comb begin
		case (alu_op)
			OP_XOR:  s = z ^ v;
			OP_AND:  s = z & v;
			OP_OR:   s = z | v;
			default: s = tot_full[WIDTH-1:0]; // Add and subtract
		endcase
	end

endmodule

// File: hw/dsp_cfg_pkg.sv
// DSP slice sizing
package dsp_cfg_pkg;

	// Data path
	localparam int DATA_W = 48; // Operand and result width
	localparam int SEG_W = 12;
	localparam int SEG_N = DATA_W / SEG_W;

	// Segments per lane for each lane mode
	localparam int SEGS_ONE48 = SEG_N;
	localparam int SEGS_TWO24 = SEG_N / 2;
	localparam int SEGS_FOUR12 = 1;

endpackage

// File: hw/dsp_ctrl_pkg.sv
// DSP slice control encodings
package dsp_ctrl_pkg;

	// ALU operation
	typedef enum logic [2:0] {
		OP_ADD = 3'd0, // z + w + x + y + cin
		OP_SUB = 3'd1, // z - (w + x + y + cin)
		OP_XOR = 3'd2,
		OP_AND = 3'd3,
		OP_OR  = 3'd4
	} alu_op_e;

	// SIMD split of the 48-bit word
	typedef enum logic [1:0] {
		LANE_ONE48  = 2'd0,
		LANE_TWO24  = 2'd1,
		LANE_FOUR12 = 2'd2
	} lane_mode_e;

	// Operand sources
	typedef enum logic [1:0] {
		X_ZERO = 2'd0,
		X_A    = 2'd1,
		X_P    = 2'd2 // Result feedback
	} x_sel_e;

	typedef enum logic [1:0] {
		Y_ZERO = 2'd0,
		Y_B    = 2'd1,
		Y_ONES = 2'd2
	} y_sel_e;

	typedef enum logic {
		W_ZERO = 1'b0,
		W_C    = 1'b1
	} w_sel_e;

	typedef enum logic [1:0] {
		Z_ZERO = 2'd0,
		Z_C    = 2'd1,
		Z_P    = 2'd2 // Result feedback
	} z_sel_e;

endpackage

// File: hw/dsp_slice.sv
// SIMD DSP slice top
`timescale 1ns/1ps

module dsp_slice (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           ce,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] a,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] b,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] c,
	input  logic                           cin,
	input  dsp_ctrl_pkg::alu_op_e          alu_op,
	input  dsp_ctrl_pkg::lane_mode_e       lane_mode,
	input  dsp_ctrl_pkg::x_sel_e           x_sel,
	input  dsp_ctrl_pkg::y_sel_e           y_sel,
	input  dsp_ctrl_pkg::w_sel_e           w_sel,
	input  dsp_ctrl_pkg::z_sel_e           z_sel,
	output logic [dsp_cfg_pkg::DATA_W-1:0] p,
	output logic [dsp_cfg_pkg::SEG_N-1:0]  carry_out
);

	import dsp_cfg_pkg::*;
	import dsp_ctrl_pkg::*;

	logic [DATA_W-1:0] w;
	logic [DATA_W-1:0] x;
	logic [DATA_W-1:0] y;
	logic [DATA_W-1:0] z;
	logic              cin_q;
	alu_op_e           alu_op_q;
	lane_mode_e        lane_mode_q;

	operand_stage u_operand_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.ce         (ce),
		.a          (a),
		.b          (b),
		.c          (c),
		.cin        (cin),
		.alu_op     (alu_op),
		.lane_mode  (lane_mode),
		.x_sel      (x_sel),
		.y_sel      (y_sel),
		.w_sel      (w_sel),
		.z_sel      (z_sel),
		.p          (p), // Feedback
		.w          (w),
		.x          (x),
		.y          (y),
		.z          (z),
		.cin_q      (cin_q),
		.alu_op_q   (alu_op_q),
		.lane_mode_q(lane_mode_q)
	);

	simd_alu u_simd_alu (
		.clk      (clk),
		.rst_n    (rst_n),
		.ce       (ce),
		.w        (w),
		.x        (x),
		.y        (y),
		.z        (z),
		.cin      (cin_q),
		.alu_op   (alu_op_q),
		.lane_mode(lane_mode_q),
		.p        (p),
		.carry_out(carry_out)
	);

endmodule

// File: hw/operand_stage.sv
// Operand register and select stage
`timescale 1ns/1ps

module operand_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           ce,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] a,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] b,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] c,
	input  logic                           cin,
	input  dsp_ctrl_pkg::alu_op_e          alu_op,
	input  dsp_ctrl_pkg::lane_mode_e       lane_mode,
	input  dsp_ctrl_pkg::x_sel_e           x_sel,
	input  dsp_ctrl_pkg::y_sel_e           y_sel,
	input  dsp_ctrl_pkg::w_sel_e           w_sel,
	input  dsp_ctrl_pkg::z_sel_e           z_sel,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] p,
	output logic [dsp_cfg_pkg::DATA_W-1:0] w,
	output logic [dsp_cfg_pkg::DATA_W-1:0] x,
	output logic [dsp_cfg_pkg::DATA_W-1:0] y,
	output logic [dsp_cfg_pkg::DATA_W-1:0] z,
	output logic                           cin_q,
	output dsp_ctrl_pkg::alu_op_e          alu_op_q,
	output dsp_ctrl_pkg::lane_mode_e       lane_mode_q
);

	import dsp_cfg_pkg::*;
	import dsp_ctrl_pkg::*;

	logic [DATA_W-1:0] a_q;
	logic [DATA_W-1:0] b_q;
	logic [DATA_W-1:0] c_q;
	x_sel_e            x_sel_q;
	y_sel_e            y_sel_q;
	w_sel_e            w_sel_q;
	z_sel_e            z_sel_q;

	// Input registers, reset leaves a slice that computes zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_q <= '0;
			b_q <= '0;
			c_q <= '0;
			cin_q <= 1'b0;
			alu_op_q <= OP_ADD;
			lane_mode_q <= LANE_ONE48;
			x_sel_q <= X_ZERO;
			y_sel_q <= Y_ZERO;
			w_sel_q <= W_ZERO;
			z_sel_q <= Z_ZERO;
		end else if (ce) begin
			a_q <= a;
			b_q <= b;
			c_q <= c;
			cin_q <= cin;
			alu_op_q <= alu_op;
			lane_mode_q <= lane_mode;
			x_sel_q <= x_sel;
			y_sel_q <= y_sel;
			w_sel_q <= w_sel;
			z_sel_q <= z_sel;
		end
	end

	// Operand muxes, p is the live result for accumulation
	always_comb begin
		case (x_sel_q)
			X_A:     x = a_q;
			X_P:     x = p;
			default: x = '0;
		endcase

		case (y_sel_q)
			Y_B:     y = b_q;
			Y_ONES:  y = '1;
			default: y = '0;
		endcase

		w = (w_sel_q == W_C) ? c_q : '0;

		case (z_sel_q)
			Z_C:     z = c_q;
			Z_P:     z = p;
			default: z = '0;
		endcase
	end

endmodule

// File: hw/simd_alu.sv
// Segmented SIMD ALU
`timescale 1ns/1ps

module simd_alu (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         ce,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] w,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] x,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] y,
	input  logic [dsp_cfg_pkg::DATA_W-1:0] z,
	input  logic                         cin,
	input  dsp_ctrl_pkg::alu_op_e        alu_op,
	input  dsp_ctrl_pkg::lane_mode_e     lane_mode,
	output logic [dsp_cfg_pkg::DATA_W-1:0] p,
	output logic [dsp_cfg_pkg::SEG_N-1:0]  carry_out
);

	import dsp_cfg_pkg::*;
	import dsp_ctrl_pkg::*;

	logic [1:0] sum_cin [SEG_N];
	logic [1:0] tot_cin [SEG_N];
	logic [1:0] sum_cout [SEG_N];
	logic [1:0] tot_cout [SEG_N];

	logic [DATA_W-1:0] s;
	logic [SEG_N-1:0]  cout_d;
	logic              add_op;
	logic              sub_one;

	// True when segment k opens a lane, k == SEG_N counts as the next word
	function automatic logic lane_start(lane_mode_e mode, int unsigned k);
		case (mode)
			LANE_TWO24:  return (k % SEGS_TWO24) == 0;
			LANE_FOUR12: return (k % SEGS_FOUR12) == 0;
			default:     return (k % SEGS_ONE48) == 0;
		endcase
	endfunction

	// Opcode decode
	assign add_op = (alu_op == OP_ADD);
	assign sub_one = (alu_op == OP_SUB); // +1 of the two's complement

	for (genvar k = 0; k < SEG_N; k++) begin : g_seg
		logic lane_top;

		if (k == 0) begin : g_first
			assign sum_cin[k] = {1'b0, cin};
			assign tot_cin[k] = {1'b0, sub_one};
		end else begin : g_next
			logic cut;

			// Cut both chains at a lane border
			assign cut = lane_start(lane_mode, k);
			assign sum_cin[k] = cut ? 2'b00 : sum_cout[k-1];
			assign tot_cin[k] = cut ? {1'b0, sub_one} : tot_cout[k-1];
		end

		assign lane_top = lane_start(lane_mode, k + 1);

		// Bit lane-width of z + w + x + y + cin
		assign cout_d[k] = (add_op && lane_top) ? (sum_cout[k][0] ^ tot_cout[k][0]) : 1'b0;

		alu_segment #(
			.WIDTH(SEG_W)
		) u_seg (
			.w       (w[k*SEG_W +: SEG_W]),
			.x       (x[k*SEG_W +: SEG_W]),
			.y       (y[k*SEG_W +: SEG_W]),
			.z       (z[k*SEG_W +: SEG_W]),
			.alu_op  (alu_op),
			.sum_cin (sum_cin[k]),
			.tot_cin (tot_cin[k]),
			.s       (s[k*SEG_W +: SEG_W]),
			.sum_cout(sum_cout[k]),
			.tot_cout(tot_cout[k])
		);
	end

	// Result register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			p <= '0;
			carry_out <= '0;
		end else if (ce) begin
			p <= s;
			carry_out <= cout_d;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_dsp_slice \
	-f filelist.f \
	--Mdir obj_dir -o sim_dsp

./obj_dir/sim_dsp | tee sim.log

if grep -q "^All checks passed$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: sim/dsp_model.svh
// DSP slice reference model
`ifndef DSP_MODEL_SVH
`define DSP_MODEL_SVH

// Lane width in bits
function automatic int lane_width(input lane_mode_e mode);
	case (mode)
		LANE_TWO24:  return 2 * SEG_W;
		LANE_FOUR12: return SEG_W;
		default:     return DATA_W;
	endcase
endfunction

// One lane of a word, right aligned
function automatic logic [63:0] lane_field(input logic [DATA_W-1:0] v, input int l, input int lw);
	return (64'(v) >> (l * lw)) & ((64'd1 << lw) - 64'd1);
endfunction

// Unreduced lane result, bits above the lane width still present
function automatic logic [63:0] lane_raw(input alu_op_e op, input int lw, input int l,
		input logic [DATA_W-1:0] w, x, y, z, input logic cin);
	logic [63:0] term;
	logic [63:0] zl;
	term = lane_field(w, l, lw) + lane_field(x, l, lw) + lane_field(y, l, lw);
	if (l == 0)
		term = term + 64'(cin); // Only the lowest lane sees cin
	zl = lane_field(z, l, lw);
	case (op)
		OP_ADD:  return zl + term;
		OP_SUB:  return zl - term;
		OP_XOR:  return zl ^ term;
		OP_AND:  return zl & term;
		default: return zl | term;
	endcase
endfunction

function automatic logic [DATA_W-1:0] expect_p(input alu_op_e op, input lane_mode_e mode,
		input logic [DATA_W-1:0] w, x, y, z, input logic cin);
	int lw;
	logic [63:0] mask;
	logic [63:0] acc;
	lw = lane_width(mode);
	mask = (64'd1 << lw) - 64'd1;
	acc = '0;
	for (int l = 0; l < DATA_W / lw; l++)
		acc = acc | ((lane_raw(op, lw, l, w, x, y, z, cin) & mask) << (l * lw));
	return acc[DATA_W-1:0];
endfunction

// Bit lane-width of the add, placed at the lane's top segment
function automatic logic [SEG_N-1:0] expect_carry(input alu_op_e op, input lane_mode_e mode,
		input logic [DATA_W-1:0] w, x, y, z, input logic cin);
	int lw;
	logic [63:0] acc;
	lw = lane_width(mode);
	acc = '0;
	if (op == OP_ADD) begin
		for (int l = 0; l < DATA_W / lw; l++)
			acc = acc | (((lane_raw(op, lw, l, w, x, y, z, cin) >> lw) & 64'd1)
				<< ((l + 1) * (lw / SEG_W) - 1));
	end
	return acc[SEG_N-1:0];
endfunction

`endif

// File: sim/tb_dsp_slice.sv
// DSP slice testbench
`timescale 1ns/1ps

module tb_dsp_slice;

	import dsp_cfg_pkg::*;
	import dsp_ctrl_pkg::*;

	`include "dsp_model.svh"

	localparam int N_ADD = 300;
	localparam int N_LANE = 120; // Per lane mode
	localparam int N_LOGIC = 90;
	localparam int N_ACC = 10;
	localparam int HOLD_CYCLES = 5;
	localparam int MAX_CYCLES = 2000; // About twice the total test length
	localparam logic [31:0] SEED = 32'hcdc8_9340;
	localparam logic [DATA_W-1:0] SEG_LSBS = 48'h001_001_001_001;

	logic              clk;
	logic              rst_n;
	logic              ce;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [DATA_W-1:0] c;
	logic              cin;
	alu_op_e           alu_op;
	lane_mode_e        lane_mode;
	x_sel_e            x_sel;
	y_sel_e            y_sel;
	w_sel_e            w_sel;
	z_sel_e            z_sel;
	logic [DATA_W-1:0] p;
	logic [SEG_N-1:0]  carry_out;

	logic [DATA_W-1:0] in_exp_p;
	logic [SEG_N-1:0]  in_exp_co;
	logic [DATA_W-1:0] model_p; // Result the next op sees on p
	logic [DATA_W-1:0] exp_p_q [$];
	logic [SEG_N-1:0]  exp_co_q [$];
	string             name_q [$];
	logic              due_valid;
	logic [DATA_W-1:0] due_p;
	logic [SEG_N-1:0]  due_co;
	string             due_name;
	string             cur_test;
	int                errors;
	int                test_errors;
	int                checks;
	int                tests;
	int                cycle_count;

	dsp_slice UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.ce       (ce),
		.a        (a),
		.b        (b),
		.c        (c),
		.cin      (cin),
		.alu_op   (alu_op),
		.lane_mode(lane_mode),
		.x_sel    (x_sel),
		.y_sel    (y_sel),
		.w_sel    (w_sel),
		.z_sel    (z_sel),
		.p        (p),
		.carry_out(carry_out)
	);

	always #5 clk = ~clk;

	// Expected entry enters on capture and falls due one capture later
	always @(posedge clk) begin
		if (rst_n && ce) begin
			exp_p_q.push_back(in_exp_p);
			exp_co_q.push_back(in_exp_co);
			name_q.push_back(cur_test);
			if (exp_p_q.size() > 1) begin
				due_p = exp_p_q.pop_front();
				due_co = exp_co_q.pop_front();
				due_name = name_q.pop_front();
				due_valid = 1'b1;
			end
		end
	end

	always @(negedge clk) begin
		if (due_valid) begin
			checks = checks + 2;
			assert (p == due_p) else begin
				$display("error %s: p expected %h, actual %h", due_name, due_p, p);
				errors++;
				test_errors++;
			end
			assert (carry_out == due_co) else begin
				$display("error %s: carry_out expected %b, actual %b", due_name, due_co, carry_out);
				errors++;
				test_errors++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [DATA_W-1:0] rand48();
		return {16'($urandom()), $urandom()};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Drive one op and record what it must produce
	task automatic issue_op(input alu_op_e op, input lane_mode_e mode, input x_sel_e xs,
			input y_sel_e ys, input w_sel_e ws, input z_sel_e zs,
			input logic [DATA_W-1:0] av, bv, cv, input logic ci);
		logic [DATA_W-1:0] wv;
		logic [DATA_W-1:0] xv;
		logic [DATA_W-1:0] yv;
		logic [DATA_W-1:0] zv;
		alu_op = op;
		lane_mode = mode;
		x_sel = xs;
		y_sel = ys;
		w_sel = ws;
		z_sel = zs;
		a = av;
		b = bv;
		c = cv;
		cin = ci;
		xv = (xs == X_A) ? av : (xs == X_P) ? model_p : '0;
		yv = (ys == Y_B) ? bv : (ys == Y_ONES) ? {DATA_W{1'b1}} : '0;
		wv = (ws == W_C) ? cv : '0;
		zv = (zs == Z_C) ? cv : (zs == Z_P) ? model_p : '0;
		in_exp_p = expect_p(op, mode, wv, xv, yv, zv, ci);
		in_exp_co = expect_carry(op, mode, wv, xv, yv, zv, ci);
		model_p = in_exp_p;
		next_cycle();
	endtask

	task automatic issue_idle();
		issue_op(OP_ADD, LANE_ONE48, X_ZERO, Y_ZERO, W_ZERO, Z_ZERO, '0, '0, '0, 1'b0);
	endtask

	task automatic check_held(input logic [DATA_W-1:0] exp_p, input logic [SEG_N-1:0] exp_co);
		checks = checks + 2;
		assert (p == exp_p) else begin
			$display("error %s: p expected %h, actual %h", cur_test, exp_p, p);
			errors++;
			test_errors++;
		end
		assert (carry_out == exp_co) else begin
			$display("error %s: carry_out expected %b, actual %b", cur_test, exp_co, carry_out);
			errors++;
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	// Idle op flushes the pipeline before the summary
	task automatic end_test();
		issue_idle();
		repeat (2) next_cycle();
		tests++;
		if (test_errors == 0)
			$display("test %s: ok", cur_test);
		else
			$display("test %s: %0d errors", cur_test, test_errors);
	endtask

	task automatic run_reset();
		begin_test("reset");
		repeat (3) begin
			next_cycle();
			check_held('0, '0);
		end
		rst_n = 1'b1;
		next_cycle();
		check_held('0, '0); // First edge out of reset
		end_test();
	endtask

	task automatic run_add48();
		begin_test("add48");
		for (int i = 0; i < N_ADD; i++)
			issue_op(OP_ADD, LANE_ONE48, X_A, Y_B, W_C, Z_C, rand48(), rand48(), rand48(),
				1'($urandom()));
		end_test();
	endtask

	task automatic run_lane_mode(input lane_mode_e mode);
		for (int i = 0; i < N_LANE; i++) begin
			case (i % 4)
				0: issue_op(OP_ADD, mode, X_A, Y_B, W_ZERO, Z_C, '1, rand48(),
					rand48() | SEG_LSBS, 1'($urandom())); // Every lane overflows
				1: issue_op(OP_SUB, mode, X_A, Y_ZERO, W_ZERO, Z_C, rand48() | SEG_LSBS,
					'0, '0, 1'($urandom())); // Borrow in every lane
				2: issue_op(OP_ADD, mode, X_A, Y_ONES, W_C, Z_C, rand48(), '0, rand48(), 1'b1);
				default: issue_op(OP_SUB, mode, X_A, Y_B, W_C, Z_C, rand48(), rand48(),
					rand48(), 1'($urandom()));
			endcase
		end
	endtask

	task automatic run_logic_mode(input lane_mode_e mode);
		alu_op_e op;
		for (int i = 0; i < N_LOGIC; i++) begin
			case (i % 3)
				0:       op = OP_XOR;
				1:       op = OP_AND;
				default: op = OP_OR;
			endcase
			issue_op(op, mode, X_A, Y_B, W_C, Z_C, rand48(), rand48(), rand48(),
				1'($urandom()));
		end
	endtask

	task automatic run_accum_hold();
		logic [DATA_W-1:0] held_p;
		logic [SEG_N-1:0]  held_co;
		begin_test("accum_hold");
		for (int i = 0; i < N_ACC; i++)
			issue_op(OP_ADD, LANE_ONE48, X_P, Y_B, W_ZERO, Z_ZERO, '0, rand48(), '0, 1'b0);
		ce = 1'b0;
		held_p = due_p; // Model result now on p
		held_co = due_co;
		repeat (HOLD_CYCLES) begin
			next_cycle();
			check_held(held_p, held_co);
		end
		ce = 1'b1;
		for (int i = 0; i < N_ACC; i++)
			issue_op(OP_ADD, LANE_FOUR12, X_A, Y_ZERO, W_ZERO, Z_P, rand48(), '0, '0,
				1'($urandom()));
		end_test();
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst_n = 1'b0;
		ce = 1'b1;
		a = '0;
		b = '0;
		c = '0;
		cin = 1'b0;
		alu_op = OP_ADD;
		lane_mode = LANE_ONE48;
		x_sel = X_ZERO;
		y_sel = Y_ZERO;
		w_sel = W_ZERO;
		z_sel = Z_ZERO;
		in_exp_p = '0;
		in_exp_co = '0;
		model_p = '0;
		due_valid = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		cycle_count = 0;
		cur_test = "reset";

		run_reset();
		run_add48();
		begin_test("lanes");
		run_lane_mode(LANE_TWO24);
		run_lane_mode(LANE_FOUR12);
		end_test();
		begin_test("logic");
		run_logic_mode(LANE_ONE48);
		run_logic_mode(LANE_TWO24);
		run_logic_mode(LANE_FOUR12);
		end_test();
		run_accum_hold();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
